// ==== include/udp_tx_params.svh ====
`ifndef UDP_TX_PARAMS_SVH
`define UDP_TX_PARAMS_SVH

// Header sizes in bytes.
`define UDP_HDR_LEN 8
`define IPV4_HDR_LEN 20

// Fixed IPv4 fields.
`define IPV4_TTL 8'd128
`define IPV4_PROTO_UDP 8'd17
`define IPV4_VER_IHL 8'h45

`endif

// ==== verilog/udp_tx_pkg.sv ====
`include "udp_tx_params.svh"

package udp_tx_pkg;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] csum;
  } udp_hdr_t;

  // Field view for the builder, byte view for the shifter.
  typedef union packed {
    udp_hdr_t                       f;
    logic [`UDP_HDR_LEN-1:0][7:0]   b;
  } udp_hdr_u;

  typedef struct packed {
    logic [7:0]  ver_ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] id;
    logic [15:0] flags_fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] csum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ipv4_hdr_t;

  // Half-word view feeds the checksum; index 9 is the first on the wire.
  typedef union packed {
    ipv4_hdr_t                         f;
    logic [`IPV4_HDR_LEN-1:0][7:0]     b;
    logic [`IPV4_HDR_LEN/2-1:0][15:0]  hw;
  } ipv4_hdr_u;

endpackage

// ==== verilog/ipv4_csum.sv ====
`timescale 1ns/1ps
`include "udp_tx_params.svh"

module ipv4_csum import udp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        csum_start,
  input  ipv4_hdr_u   hdr_words,
  output logic        csum_done,
  output logic [15:0] csum
);

  logic [3:0]  idx;
  logic        busy;
  logic [15:0] acc;
  logic [16:0] sum;
  logic [15:0] fold;

  assign sum  = {1'b0, acc} + {1'b0, hdr_words.hw[idx]};
  assign fold = sum[15:0] + {15'd0, sum[16]}; // End-around carry.

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy      <= 1'b0;
      idx       <= 4'd0;
      csum_done <= 1'b0;
    end else begin
      csum_done <= 1'b0;
      if (csum_start) begin
        busy <= 1'b1;
        idx  <= 4'd0;
      end else if (busy) begin
        if (idx == 4'(`IPV4_HDR_LEN/2 - 1)) begin
          busy      <= 1'b0;
          csum_done <= 1'b1;
        end else begin
          idx <= idx + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (csum_start) acc <= 16'h0000;
    else if (busy) acc <= fold;
    if (busy && idx == 4'(`IPV4_HDR_LEN/2 - 1)) csum <= ~fold; // Last word.
  end

endmodule

// ==== verilog/udp_hdr_tx.sv ====
`timescale 1ns/1ps
`include "udp_tx_params.svh"

module udp_hdr_tx import udp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        pkt_rdy,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [15:0] ip_id,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [15:0] pld_len,
  input  logic [7:0]  pld_dat,
  input  logic        pld_val,
  input  logic        pld_eof,
  input  logic        pld_err,
  input  logic        udp_req,
  output logic        pld_req,
  output logic        udp_rdy,
  output logic [31:0] ip_src,
  output logic [31:0] ip_dst,
  output logic [15:0] ip_id_o,
  output logic [15:0] udp_len,
  output logic        udp_val,
  output logic [7:0]  udp_dat,
  output logic        udp_eof
);

  udp_hdr_u   hdr;       // Header shift register.
  logic [3:0] byte_cnt;  // Bytes sent, stops at header length.
  logic       hdr_done;
  logic       busy;
  logic       capture;
  logic       clr;

  assign capture  = !busy && pkt_rdy;
  assign hdr_done = (byte_cnt == 4'(`UDP_HDR_LEN));
  assign clr      = fsm_rst || udp_eof || pld_err;

  always_ff @(posedge clk) begin
    if (clr) begin
      busy     <= 1'b0;
      udp_rdy  <= 1'b0;
      udp_val  <= 1'b0;
      pld_req  <= 1'b0;
      byte_cnt <= 4'd0;
    end else begin
      if (capture) begin
        busy    <= 1'b1;
        udp_rdy <= 1'b1;
      end
      if (udp_req) udp_val <= 1'b1;
      if (udp_val && !hdr_done) byte_cnt <= byte_cnt + 4'd1;
      // Two cycles of payload latency, so ask early.
      if (udp_val && byte_cnt == 4'(`UDP_HDR_LEN - 3)) pld_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      hdr.f.src_port <= src_port;
      hdr.f.dst_port <= dst_port;
      hdr.f.length   <= pld_len + 16'(`UDP_HDR_LEN);
      hdr.f.csum     <= 16'h0000; // Optional in IPv4.
      ip_src         <= src_ip;
      ip_dst         <= dst_ip;
      ip_id_o        <= ip_id;
      udp_len        <= pld_len + 16'(`UDP_HDR_LEN);
    end else if (udp_val) begin
      hdr.b <= {hdr.b[`UDP_HDR_LEN-2:0], 8'h00};
    end
  end

  assign udp_dat = hdr_done ? pld_dat : hdr.b[`UDP_HDR_LEN-1];
  assign udp_eof = udp_val && pld_val && pld_eof;

endmodule

// ==== verilog/ipv4_hdr_tx.sv ====
`timescale 1ns/1ps
`include "udp_tx_params.svh"

module ipv4_hdr_tx import udp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        udp_rdy,
  input  logic [31:0] ip_src,
  input  logic [31:0] ip_dst,
  input  logic [15:0] ip_id_o,
  input  logic [15:0] udp_len,
  input  logic        udp_val,
  input  logic [7:0]  udp_dat,
  input  logic        udp_eof,
  input  logic        pld_err,
  input  logic        out_req,
  output logic        udp_req,
  output logic        out_rdy,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic [7:0]  out_dat
);

  ipv4_hdr_u   hdr_calc;  // Zero checksum, summed as is.
  ipv4_hdr_u   hdr;       // Final header, shifted out.
  logic        csum_start;
  logic        csum_done;
  logic [15:0] csum;
  logic        started;
  logic [4:0]  byte_cnt;
  logic        hdr_done;
  logic        clr;

  always_comb begin
    hdr_calc.f.ver_ihl   = `IPV4_VER_IHL;
    hdr_calc.f.tos       = 8'h00;
    hdr_calc.f.total_len = udp_len + 16'(`IPV4_HDR_LEN);
    hdr_calc.f.id        = ip_id_o;
    hdr_calc.f.flags_fo  = 16'h0000; // No fragments.
    hdr_calc.f.ttl       = `IPV4_TTL;
    hdr_calc.f.proto     = `IPV4_PROTO_UDP;
    hdr_calc.f.csum      = 16'h0000;
    hdr_calc.f.src_ip    = ip_src;
    hdr_calc.f.dst_ip    = ip_dst;
  end

  assign csum_start = udp_rdy && !started;
  assign hdr_done   = (byte_cnt == 5'(`IPV4_HDR_LEN));
  assign clr        = fsm_rst || out_eof || pld_err;

  ipv4_csum i_csum (
    .clk        (clk),
    .fsm_rst    (clr),
    .csum_start (csum_start),
    .hdr_words  (hdr_calc),
    .csum_done  (csum_done),
    .csum       (csum)
  );

  always_ff @(posedge clk) begin
    if (clr) begin
      started  <= 1'b0;
      out_rdy  <= 1'b0;
      out_val  <= 1'b0;
      udp_req  <= 1'b0;
      byte_cnt <= 5'd0;
    end else begin
      if (csum_start) started <= 1'b1;
      if (csum_done) out_rdy <= 1'b1;
      if (out_rdy && out_req) out_val <= 1'b1;
      if (out_val && !hdr_done) byte_cnt <= byte_cnt + 5'd1;
      // UDP byte 0 lands right after IPv4 byte 19.
      if (out_val && byte_cnt == 5'(`IPV4_HDR_LEN - 2)) udp_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (csum_done) begin
      hdr        <= hdr_calc;
      hdr.f.csum <= csum;
    end else if (out_val) begin
      hdr.b <= {hdr.b[`IPV4_HDR_LEN-2:0], 8'h00};
    end
  end

  assign out_sof = out_val && (byte_cnt == 5'd0);
  assign out_eof = out_val && udp_val && udp_eof;
  assign out_dat = hdr_done ? udp_dat : hdr.b[`IPV4_HDR_LEN-1];

endmodule

// ==== verilog/udp_tx_top.sv ====
`timescale 1ns/1ps

module udp_tx_top (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        pkt_rdy,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [15:0] ip_id,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [15:0] pld_len,
  input  logic [7:0]  pld_dat,
  input  logic        pld_val,
  input  logic        pld_eof,
  input  logic        pld_err,
  output logic        pld_req,
  input  logic        out_req,
  output logic        out_rdy,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic [7:0]  out_dat
);

  logic        udp_rdy;
  logic        udp_req;
  logic        udp_val;
  logic        udp_eof;
  logic [7:0]  udp_dat;
  logic [31:0] ip_src;
  logic [31:0] ip_dst;
  logic [15:0] ip_id_o;
  logic [15:0] udp_len;

  udp_hdr_tx i_udp (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .pkt_rdy  (pkt_rdy),
    .src_ip   (src_ip),
    .dst_ip   (dst_ip),
    .ip_id    (ip_id),
    .src_port (src_port),
    .dst_port (dst_port),
    .pld_len  (pld_len),
    .pld_dat  (pld_dat),
    .pld_val  (pld_val),
    .pld_eof  (pld_eof),
    .pld_err  (pld_err),
    .udp_req  (udp_req),
    .pld_req  (pld_req),
    .udp_rdy  (udp_rdy),
    .ip_src   (ip_src),
    .ip_dst   (ip_dst),
    .ip_id_o  (ip_id_o),
    .udp_len  (udp_len),
    .udp_val  (udp_val),
    .udp_dat  (udp_dat),
    .udp_eof  (udp_eof)
  );

  ipv4_hdr_tx i_ipv4 (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .udp_rdy  (udp_rdy),
    .ip_src   (ip_src),
    .ip_dst   (ip_dst),
    .ip_id_o  (ip_id_o),
    .udp_len  (udp_len),
    .udp_val  (udp_val),
    .udp_dat  (udp_dat),
    .udp_eof  (udp_eof),
    .pld_err  (pld_err), // Abort reaches both blocks.
    .out_req  (out_req),
    .udp_req  (udp_req),
    .out_rdy  (out_rdy),
    .out_val  (out_val),
    .out_sof  (out_sof),
    .out_eof  (out_eof),
    .out_dat  (out_dat)
  );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #2 clk = ~clk; // 4 ns period.

endmodule

// ==== tests/udp_tx_tb.sv ====
`timescale 1ns/1ps
`include "udp_tx_params.svh"

module udp_tx_tb;

  typedef logic [7:0] byte_q_t [$];

  localparam int NUM_FRAMES = 24;
  localparam int MAX_CYCLES = NUM_FRAMES * (64 + 28 + 40) + 8 + 200;

  logic        clk;
  logic        fsm_rst;
  logic        pkt_rdy, pld_val, pld_eof, pld_err, pld_req;
  logic        out_req, out_rdy, out_val, out_sof, out_eof;
  logic [31:0] src_ip, dst_ip;
  logic [15:0] ip_id, src_port, dst_port, pld_len;
  logic [7:0]  pld_dat, out_dat;

  logic [31:0] lcg_state = 32'h9fdd;
  logic [7:0]  pld_mem [0:63];    // Payload of the frame being sent.
  byte_q_t     exp_bytes;
  int          exp_len [$];
  bit          exp_abort [$];
  int          errors, frame_errs, frames_sent, frames_done;
  int          cnt, cycles, tests_ok, tests_run;
  bit          in_frame;

  tb_clk_gen i_clk (.clk(clk));

  udp_tx_top i_dut (.*);

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected wire bytes: IPv4 header, UDP header, payload.
  function automatic byte_q_t build_frame(input logic [31:0] sip, input logic [31:0] dip,
      input logic [15:0] id, input logic [15:0] sp, input logic [15:0] dp, input int len);
    byte_q_t      f;
    logic [159:0] ip;
    logic [63:0]  udp;
    logic [31:0]  sum;
    int           i;
    sum = 32'd0;
    ip = {`IPV4_VER_IHL, 8'h00, 16'(len + `IPV4_HDR_LEN + `UDP_HDR_LEN), id, 16'h0000,
          `IPV4_TTL, `IPV4_PROTO_UDP, 16'h0000, sip, dip};
    for (i = 0; i < 10; i++) sum = sum + {16'd0, ip[159 - 16*i -: 16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]}; // Second fold catches the last carry.
    ip[79:64] = ~sum[15:0];
    udp = {sp, dp, 16'(len + `UDP_HDR_LEN), 16'h0000};
    for (i = 0; i < 20; i++) f.push_back(ip[159 - 8*i -: 8]);
    for (i = 0; i < 8; i++) f.push_back(udp[63 - 8*i -: 8]);
    for (i = 0; i < len; i++) f.push_back(pld_mem[i]);
    return f;
  endfunction

  function automatic bit check_bit(input string name, input logic got, input logic want);
    assert (got === want) else begin
      $display("FAIL %0t %s expected %b got %b", $time, name, want, got);
      errors++;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Application side; err_at < 0 means no abort.
  task automatic send_frame(input int len, input int err_at, input bit hold);
    logic [31:0] sip;
    logic [31:0] dip;
    logic [31:0] r;
    logic [15:0] id;
    logic [15:0] sp;
    logic [15:0] dp;
    byte_q_t     f;
    int          i;
    sip = rand_next();
    dip = rand_next();
    r = rand_next();
    id = r[31:16];
    sp = r[15:0];
    r = rand_next();
    dp = r[31:16];
    for (i = 0; i < len; i++) begin
      r = rand_next();
      pld_mem[i] = r[23:16];
    end
    f = build_frame(sip, dip, id, sp, dp, len);
    foreach (f[k]) exp_bytes.push_back(f[k]);
    exp_len.push_back(len + `IPV4_HDR_LEN + `UDP_HDR_LEN);
    exp_abort.push_back(err_at >= 0);
    frames_sent++;
    src_ip = sip;
    dst_ip = dip;
    ip_id = id;
    src_port = sp;
    dst_port = dp;
    pld_len = 16'(len);
    pkt_rdy = 1'b1;
    do begin
      @(posedge clk);
      #1;
      if (hold) begin // Fields change under a held request.
        src_ip = rand_next();
        dst_ip = rand_next();
        r = rand_next();
        ip_id = r[31:16];
        pld_len = r[15:0];
      end
    end while (!pld_req);
    if (!hold) pkt_rdy = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    for (i = 0; i < len; i++) begin
      pld_dat = pld_mem[i];
      pld_val = 1'b1;
      pld_eof = (i == len - 1);
      pld_err = (i == err_at);
      if (i == len - 1) pkt_rdy = 1'b0;
      @(posedge clk);
      #1;
      if (i == err_at) break;
    end
    pld_val = 1'b0;
    pld_eof = 1'b0;
    pld_err = 1'b0;
  endtask

  task automatic close_frame();
    repeat (exp_len[0] - cnt) exp_bytes.delete(0);
    exp_len.delete(0);
    exp_abort.delete(0);
    in_frame = 1'b0;
    frames_done++;
  endtask

  task automatic wait_drain();
    while (frames_done != frames_sent) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input bit ok);
    tests_run++;
    if (ok) tests_ok++;
    $display("Test %0d %s: %s", num, name, ok ? "passed" : "FAILED");
  endtask

  // MAC pulls whenever a frame is offered.
  always @(posedge clk) begin
    #1;
    out_req = out_rdy;
  end

  always @(negedge clk) begin
    logic [7:0] want;
    if (out_val && out_sof) begin
      assert (!in_frame && exp_len.size() > 0) else begin
        $display("%0t: out_sof came in mid-frame or with no frame pending", $time);
        errors++;
        frame_errs++;
      end
      in_frame = (exp_len.size() > 0);
      cnt = 0;
    end
    if (out_val) begin
      assert (in_frame) else begin
        $display("%0t: out_val is high outside a frame", $time);
        errors++;
        frame_errs++;
      end
      if (in_frame) begin
        want = exp_bytes.pop_front();
        assert (out_dat == want) else begin
          $display("FAIL %0t out_dat expected %h got %h", $time, want, out_dat);
          errors++;
        end
        cnt++;
        if (!check_bit("out_eof", out_eof, cnt == exp_len[0])) frame_errs++;
        if (out_eof) begin
          assert (!exp_abort[0]) else begin
            $display("%0t: out_eof ended a frame that should have been aborted", $time);
            errors++;
          end
          close_frame();
        end
      end
    end else if (in_frame) begin
      assert (exp_abort[0]) else begin
        $display("%0t: out_val dropped before out_eof", $time);
        errors++;
        frame_errs++;
      end
      void'(check_bit("out_rdy", out_rdy, 1'b0));
      close_frame();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int          e0;
    int          i;
    logic [31:0] r;
    fsm_rst = 1'b1;
    pkt_rdy = 1'b0;
    src_ip = 32'd0;
    dst_ip = 32'd0;
    ip_id = 16'd0;
    src_port = 16'd0;
    dst_port = 16'd0;
    pld_len = 16'd0;
    pld_dat = 8'd0;
    pld_val = 1'b0;
    pld_eof = 1'b0;
    pld_err = 1'b0;
    out_req = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    fsm_rst = 1'b0;

    e0 = errors;
    repeat (10) begin
      @(negedge clk);
      void'(check_bit("out_rdy", out_rdy, 1'b0));
      void'(check_bit("out_val", out_val, 1'b0));
      void'(check_bit("pld_req", pld_req, 1'b0));
    end
    @(posedge clk);
    #1;
    report_test(1, "idle after reset", errors == e0);

    e0 = errors;
    send_frame(18, -1, 1'b0);
    wait_drain();
    report_test(2, "single 18-byte frame", errors == e0);

    e0 = errors;
    for (i = 0; i < 20; i++) begin
      r = rand_next();
      send_frame(1 + int'(r[21:16]), -1, 1'b0); // Length 1 to 64.
    end
    wait_drain();
    report_test(4, "twenty back-to-back frames", errors == e0);

    e0 = errors;
    send_frame(40, 20, 1'b0);
    send_frame(24, -1, 1'b0);
    wait_drain();
    report_test(5, "abort by pld_err", errors == e0);

    e0 = errors;
    send_frame(32, -1, 1'b1);
    wait_drain();
    report_test(6, "pkt_rdy held during a frame", errors == e0);

    report_test(3, "framing of every frame", frame_errs == 0);
    $display("Tests passed: %0d of %0d, failed checks: %0d", tests_ok, tests_run, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== udp_tx.f ====
+incdir+include
verilog/udp_tx_pkg.sv
verilog/ipv4_csum.sv
verilog/udp_hdr_tx.sv
verilog/ipv4_hdr_tx.sv
verilog/udp_tx_top.sv
tests/tb_clk_gen.sv
tests/udp_tx_tb.sv

// ==== Makefile ====
TOP = udp_tx_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f udp_tx.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
